// File: hdl/mdu_cfg.svh
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

// Operand and result width
`define MDU_XLEN 64

`define MDU_TAG_W 5

// One engine iteration per operand bit
`define MDU_STEPS `MDU_XLEN

`endif

// File: hdl/mdu_pkg.sv
`include "mdu_cfg.svh"

package mdu_pkg;

    typedef enum logic [2:0] {
        op_mul,
        op_mulh,
        op_mulhsu,
        op_mulhu,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } mdu_op_e;

    typedef struct packed {
        mdu_op_e                op;
        logic [`MDU_TAG_W-1:0]  tag;
        logic [`MDU_XLEN-1:0]   src_a;
        logic [`MDU_XLEN-1:0]   src_b;
    } mdu_req_t;

    typedef struct packed {
        logic [`MDU_TAG_W-1:0]  tag;
        logic                   a_signed;
        logic                   b_signed;
        logic                   take_high;  // Upper half of the product
        logic [`MDU_XLEN-1:0]   a;
        logic [`MDU_XLEN-1:0]   b;
    } mul_cmd_t;

    typedef struct packed {
        logic [`MDU_TAG_W-1:0]  tag;
        logic                   is_signed;
        logic                   take_rem;   // Remainder instead of quotient
        logic [`MDU_XLEN-1:0]   dividend;
        logic [`MDU_XLEN-1:0]   divisor;
    } div_cmd_t;

    typedef struct packed {
        logic [`MDU_TAG_W-1:0]  tag;
        logic [`MDU_XLEN-1:0]   data;
    } mdu_wb_t;

    typedef enum logic [1:0] {mul_idle, mul_run, mul_fix, mul_hold} mul_state_e;

    typedef enum logic [1:0] {div_idle, div_run, div_fix, div_hold} div_state_e;

endpackage

// File: hdl/mdu_dispatch.sv
`timescale 1ns/1ns

module mdu_dispatch (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              req_valid,
    input  mdu_pkg::mdu_req_t req,
    input  logic              mul_idle,
    input  logic              div_idle,
    output logic              req_ready,
    output logic              mul_start,
    output logic              div_start,
    output mdu_pkg::mul_cmd_t mul_cmd,
    output mdu_pkg::div_cmd_t div_cmd
);
    import mdu_pkg::*;

    logic is_div;
    logic accept;

    always_comb begin
        is_div             = 1'b0;
        mul_cmd.tag        = req.tag;
        mul_cmd.a          = req.src_a;
        mul_cmd.b          = req.src_b;
        mul_cmd.a_signed   = 1'b0;
        mul_cmd.b_signed   = 1'b0;
        mul_cmd.take_high  = 1'b1;
        div_cmd.tag        = req.tag;
        div_cmd.dividend   = req.src_a;
        div_cmd.divisor    = req.src_b;
        div_cmd.is_signed  = 1'b0;
        div_cmd.take_rem   = 1'b0;
        case (req.op)
            op_mul:    mul_cmd.take_high = 1'b0;  // Low half is sign independent
            op_mulh: begin
                mul_cmd.a_signed = 1'b1;
                mul_cmd.b_signed = 1'b1;
            end
            op_mulhsu: mul_cmd.a_signed = 1'b1;
            op_mulhu:  mul_cmd.take_high = 1'b1;
            op_div: begin
                is_div            = 1'b1;
                div_cmd.is_signed = 1'b1;
            end
            op_divu:   is_div = 1'b1;
            op_rem: begin
                is_div            = 1'b1;
                div_cmd.is_signed = 1'b1;
                div_cmd.take_rem  = 1'b1;
            end
            default: begin
                is_div           = 1'b1;
                div_cmd.take_rem = 1'b1;
            end
        endcase
    end

    assign req_ready = !flush && (is_div ? div_idle : mul_idle);
    assign accept    = req_valid && req_ready;
    assign mul_start = accept && !is_div;
    assign div_start = accept && is_div;

endmodule

// File: hdl/mdu_mul.sv
`timescale 1ns/1ns
`include "mdu_cfg.svh"

module mdu_mul (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              start,
    input  mdu_pkg::mul_cmd_t cmd,
    input  logic              grant,
    output logic              idle,
    output logic              done,
    output mdu_pkg::mdu_wb_t  result
);
    import mdu_pkg::*;

    localparam int XLEN  = `MDU_XLEN;
    localparam int CNT_W = $clog2(`MDU_STEPS);

    mul_state_e        state_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [2*XLEN-1:0] mcand_q;   // Multiplicand, shifted left every step
    logic [XLEN-1:0]   mplier_q;  // Multiplier, shifted right every step
    logic [2*XLEN-1:0] prod_q;
    logic [2*XLEN-1:0] addend;
    logic              b_neg_q;
    logic              high_q;
    logic              last_step;
    mdu_wb_t           res_q;

    assign addend    = mplier_q[0] ? mcand_q : '0;
    assign last_step = (cnt_q == CNT_W'(`MDU_STEPS - 1));

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state_q <= mul_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                mul_idle: begin
                    if (start) begin
                        state_q <= mul_run;
                        cnt_q   <= '0;
                    end
                end
                mul_run: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_step) begin
                        state_q <= mul_fix;
                    end
                end
                mul_fix:  state_q <= mul_hold;
                default: begin
                    if (grant) begin
                        state_q <= mul_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == mul_idle && start) begin
            mcand_q   <= {{XLEN{cmd.a_signed & cmd.a[XLEN-1]}}, cmd.a};
            mplier_q  <= cmd.b;
            prod_q    <= '0;
            b_neg_q   <= cmd.b_signed & cmd.b[XLEN-1];
            high_q    <= cmd.take_high;
            res_q.tag <= cmd.tag;
        end else if (state_q == mul_run) begin
            // The sign bit of a negative multiplier weighs -2^(XLEN-1)
            if (last_step && b_neg_q) begin
                prod_q <= prod_q - addend;
            end else begin
                prod_q <= prod_q + addend;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end else if (state_q == mul_fix) begin
            res_q.data <= high_q ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];
        end
    end

    assign idle   = (state_q == mul_idle);
    assign done   = (state_q == mul_hold) && !flush;  // A flushed result is never offered
    assign result = res_q;

endmodule

// File: hdl/mdu_div.sv
`timescale 1ns/1ns
`include "mdu_cfg.svh"

module mdu_div (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              start,
    input  mdu_pkg::div_cmd_t cmd,
    input  logic              grant,
    output logic              idle,
    output logic              done,
    output mdu_pkg::mdu_wb_t  result
);
    import mdu_pkg::*;

    localparam int XLEN  = `MDU_XLEN;
    localparam int CNT_W = $clog2(`MDU_STEPS);

    div_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]  quo_q;   // Holds the dividend magnitude, then the quotient
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  dvsr_q;
    logic [XLEN:0]    rem_shift;
    logic [XLEN:0]    diff;
    logic             q_neg_q;
    logic             r_neg_q;
    logic             take_rem_q;
    logic             last_step;
    logic             fix_first;
    mdu_wb_t          res_q;

    function automatic logic [XLEN-1:0] magnitude(input logic [XLEN-1:0] v, input logic sgn);
        return (sgn && v[XLEN-1]) ? -v : v;
    endfunction

    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign diff      = rem_shift - {1'b0, dvsr_q};
    assign last_step = (cnt_q == CNT_W'(`MDU_STEPS - 1));
    assign fix_first = (cnt_q == '0);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state_q <= div_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                div_idle: begin
                    if (start) begin
                        state_q <= div_run;
                        cnt_q   <= '0;
                    end
                end
                div_run: begin
                    if (last_step) begin
                        state_q <= div_fix;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                div_fix: begin  // Two cycles, sign fix-up then selection
                    cnt_q <= cnt_q + 1'b1;
                    if (!fix_first) begin
                        state_q <= div_hold;
                    end
                end
                default: begin
                    if (grant) begin
                        state_q <= div_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == div_idle && start) begin
            quo_q      <= magnitude(cmd.dividend, cmd.is_signed);
            dvsr_q     <= magnitude(cmd.divisor, cmd.is_signed);
            rem_q      <= '0;
            // A zero divisor leaves an all-ones quotient and the dividend as remainder
            q_neg_q    <= cmd.is_signed && (cmd.dividend[XLEN-1] ^ cmd.divisor[XLEN-1])
                          && (cmd.divisor != '0);
            r_neg_q    <= cmd.is_signed && cmd.dividend[XLEN-1];
            take_rem_q <= cmd.take_rem;
            res_q.tag  <= cmd.tag;
        end else if (state_q == div_run) begin
            if (diff[XLEN]) begin
                rem_q <= rem_shift[XLEN-1:0];  // Trial subtract failed, restore
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end else begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end
        end else if (state_q == div_fix) begin
            if (fix_first) begin
                // The most negative dividend over -1 wraps back to itself
                quo_q <= q_neg_q ? -quo_q : quo_q;
                rem_q <= r_neg_q ? -rem_q : rem_q;
            end else begin
                res_q.data <= take_rem_q ? rem_q : quo_q;
            end
        end
    end

    assign idle   = (state_q == div_idle);
    assign done   = (state_q == div_hold) && !flush;
    assign result = res_q;

endmodule

// File: hdl/mdu_wb_arbiter.sv
`timescale 1ns/1ns

module mdu_wb_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  logic             mul_done,
    input  logic             div_done,
    input  mdu_pkg::mdu_wb_t mul_res,
    input  mdu_pkg::mdu_wb_t div_res,
    output logic             mul_grant,
    output logic             div_grant,
    output logic             wb_valid,
    output mdu_pkg::mdu_wb_t wb
);
    import mdu_pkg::*;

    logic last_mul_q;  // Multiplier won the most recent grant

    // On a tie the engine that did not win last time goes first
    assign mul_grant = mul_done && (!div_done || !last_mul_q);
    assign div_grant = div_done && (!mul_done || last_mul_q);

    assign wb_valid = mul_grant || div_grant;

    always_comb begin
        if (mul_grant) begin
            wb = mul_res;
        end else begin
            wb = div_res;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_mul_q <= 1'b0;
        end else if (mul_grant) begin
            last_mul_q <= 1'b1;
        end else if (div_grant) begin
            last_mul_q <= 1'b0;
        end
    end

endmodule

// File: hdl/mdu_top.sv
`timescale 1ns/1ns

module mdu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              req_valid,
    input  mdu_pkg::mdu_req_t req,
    output logic              req_ready,
    output logic              wb_valid,
    output mdu_pkg::mdu_wb_t  wb
);
    import mdu_pkg::*;

    logic     mul_free;
    logic     div_free;
    logic     mul_start;
    logic     div_start;
    mul_cmd_t mul_cmd;
    div_cmd_t div_cmd;
    logic     mul_done;
    logic     div_done;
    logic     mul_grant;
    logic     div_grant;
    mdu_wb_t  mul_res;
    mdu_wb_t  div_res;

    mdu_dispatch u_dispatch (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .req_valid (req_valid),
        .req       (req),
        .mul_idle  (mul_free),
        .div_idle  (div_free),
        .req_ready (req_ready),
        .mul_start (mul_start),
        .div_start (div_start),
        .mul_cmd   (mul_cmd),
        .div_cmd   (div_cmd)
    );

    mdu_mul u_mul (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .start  (mul_start),
        .cmd    (mul_cmd),
        .grant  (mul_grant),
        .idle   (mul_free),
        .done   (mul_done),
        .result (mul_res)
    );

    mdu_div u_div (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .start  (div_start),
        .cmd    (div_cmd),
        .grant  (div_grant),
        .idle   (div_free),
        .done   (div_done),
        .result (div_res)
    );

    mdu_wb_arbiter u_wb_arbiter (
        .clk       (clk),
        .rst       (rst),
        .mul_done  (mul_done),
        .div_done  (div_done),
        .mul_res   (mul_res),
        .div_res   (div_res),
        .mul_grant (mul_grant),
        .div_grant (div_grant),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

endmodule

// File: verification/mdu_assertions.sv
`timescale 1ns/1ns

module mdu_assertions (
    input logic             clk,
    input logic             rst,
    input logic             flush,
    input logic             req_ready,
    input logic             wb_valid,
    input mdu_pkg::mdu_wb_t wb
);

    // A flushed engine never offers its result
    a_quiet_after_flush: assert property (
        @(posedge clk) disable iff (rst) flush |=> !wb_valid
    ) else $error("wb_valid high in the cycle after flush");

    a_ready_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> req_ready
    ) else $error("req_ready low in the first cycle after reset");

    a_tag_known: assert property (
        @(posedge clk) disable iff (rst) wb_valid |-> !$isunknown(wb.tag)
    ) else $error("wb.tag has unknown bits while wb_valid is high");

endmodule

// File: verification/mdu_tb.sv
`timescale 1ns/1ns
`include "mdu_cfg.svh"

module mdu_tb;
    import mdu_pkg::*;

    localparam int XLEN     = `MDU_XLEN;
    localparam int NUM_TAGS = 2 ** `MDU_TAG_W;
    localparam int NUM_VECS = 22;
    localparam int DRIVE    = 10;  // Inputs change this long after the rising edge
    // Three more requests come from the flush test
    localparam int LIMIT    = (NUM_VECS + 3) * (2 * `MDU_STEPS + 8) + 100;
    localparam logic [XLEN-1:0] M1  = '1;
    localparam logic [XLEN-1:0] MIN = {1'b1, {(XLEN-1){1'b0}}};

    typedef struct packed {
        mdu_op_e               op;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [`MDU_TAG_W-1:0] tag;
        logic [XLEN-1:0]       exp;
        logic                  back;  // Issued with no idle gap before it
    } vec_t;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                req_valid;
    mdu_req_t            req;
    logic                req_ready;
    logic                wb_valid;
    mdu_wb_t             wb;
    vec_t                vecs [NUM_VECS];
    logic [XLEN-1:0]     exp_data [NUM_TAGS];
    int                  wb_cycle [NUM_TAGS];  // Cycle count at each tag's writeback
    logic [NUM_TAGS-1:0] pend;      // Tags accepted and not yet written back
    logic [NUM_TAGS-1:0] pend_div;  // Tag went to the divider
    logic                busy_mul = 1'b0;
    logic                busy_div = 1'b0;
    int                  cycles = 0;
    int                  seed;
    int                  gap;

    mdu_top u_mdu_top (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

    bind mdu_top mdu_assertions u_assertions (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .req_ready (req_ready),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    function automatic logic op_is_div(input mdu_op_e op);
        return op inside {op_div, op_divu, op_rem, op_remu};
    endfunction

    // Holds the request until it is taken and checks req_ready on every try
    task automatic issue(input mdu_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                         input logic [`MDU_TAG_W-1:0] tag, input logic [XLEN-1:0] exp);
        logic is_div;
        logic exp_ready;
        logic taken;
        is_div    = op_is_div(op);
        req.op    = op;
        req.tag   = tag;
        req.src_a = a;
        req.src_b = b;
        req_valid = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            exp_ready = !(is_div ? busy_div : busy_mul);
            check("req_ready", XLEN'(req_ready), XLEN'(exp_ready));
            taken = req_ready;
            @(posedge clk);
            #DRIVE;
        end
        req_valid     = 1'b0;
        pend[tag]     = 1'b1;
        pend_div[tag] = is_div;
        exp_data[tag] = exp;
        if (is_div) begin
            busy_div <= 1'b1;
        end else begin
            busy_mul <= 1'b1;
        end
    endtask

    task automatic wait_drain();
        while (pend != '0) begin
            @(posedge clk);
            #DRIVE;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if ($isunknown(wb.tag) || !pend[wb.tag]) begin
                report_failure($sformatf("Writeback with unexpected tag %0d at %0t ns",
                                         wb.tag, $time));
            end
            check("wb.data", wb.data, exp_data[wb.tag]);
            pend[wb.tag]     = 1'b0;
            wb_cycle[wb.tag] = cycles;
            if (pend_div[wb.tag]) begin
                busy_div <= 1'b0;  // Engine is idle again after this edge
            end else begin
                busy_mul <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            report_failure("Timeout: the results did not arrive within the cycle limit");
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        pend      = '0;
        pend_div  = '0;
        seed      = 78;
        gap       = 0;
        vecs[0]  = '{op_mul, 64'd7, 64'd6, 5'd1, 64'h2a, 1'b0};
        vecs[1]  = '{op_mulh, M1, M1, 5'd2, 64'd0, 1'b0};
        vecs[2]  = '{op_mulhu, M1, M1, 5'd3, 64'hffff_ffff_ffff_fffe, 1'b0};
        vecs[3]  = '{op_mulhsu, M1, M1, 5'd4, M1, 1'b0};
        vecs[4]  = '{op_mul, MIN, M1, 5'd5, MIN, 1'b0};
        vecs[5]  = '{op_mulh, MIN, MIN, 5'd6, 64'h4000_0000_0000_0000, 1'b0};
        vecs[6]  = '{op_mulhu, MIN, 64'd2, 5'd7, 64'd1, 1'b0};
        vecs[7]  = '{op_mulh, 64'h1_0000_0000, 64'hffff_ffff_0000_0000, 5'd8, M1, 1'b0};
        vecs[8]  = '{op_mul, 64'd0, 64'h1234, 5'd9, 64'd0, 1'b0};
        vecs[9]  = '{op_mulhsu, 64'd2, M1, 5'd10, 64'd1, 1'b0};
        // Divide right behind a multiply
        vecs[10] = '{op_div, 64'd20, 64'hffff_ffff_ffff_fffd, 5'd11, 64'hffff_ffff_ffff_fffa, 1'b1};
        vecs[11] = '{op_rem, 64'd20, 64'hffff_ffff_ffff_fffd, 5'd12, 64'd2, 1'b0};
        // Accepted one cycle after the divide so both finish together
        vecs[12] = '{op_mul, 64'd3, 64'd5, 5'd13, 64'hf, 1'b1};
        vecs[13] = '{op_rem, 64'hffff_ffff_ffff_ffec, 64'd3, 5'd14, 64'hffff_ffff_ffff_fffe, 1'b0};
        vecs[14] = '{op_divu, M1, 64'd2, 5'd15, 64'h7fff_ffff_ffff_ffff, 1'b0};
        vecs[15] = '{op_remu, M1, 64'd10, 5'd16, 64'd5, 1'b0};
        vecs[16] = '{op_div, 64'hffff_ffff_ffff_fff9, 64'd0, 5'd17, M1, 1'b0};
        vecs[17] = '{op_remu, 64'hffff_ffff_ffff_fffb, 64'd0, 5'd18, 64'hffff_ffff_ffff_fffb, 1'b0};
        vecs[18] = '{op_div, MIN, M1, 5'd19, MIN, 1'b0};
        vecs[19] = '{op_rem, MIN, M1, 5'd20, 64'd0, 1'b0};
        vecs[20] = '{op_divu, MIN, 64'h10, 5'd21, 64'h0800_0000_0000_0000, 1'b0};
        vecs[21] = '{op_div, 64'hffff_ffff_ffff_ff9c, 64'd7, 5'd22, 64'hffff_ffff_ffff_fff2, 1'b0};
        repeat (8) @(posedge clk);
        #DRIVE;
        rst = 1'b0;
        for (int i = 0; i < NUM_VECS; i++) begin
            gap = vecs[i].back ? 0 : $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                #DRIVE;
            end
            issue(vecs[i].op, vecs[i].a, vecs[i].b, vecs[i].tag, vecs[i].exp);
        end
        wait_drain();
        // The multiplier wins this tie because the divider was granted last
        check("tag 12 writeback cycle", XLEN'(wb_cycle[12]), XLEN'(wb_cycle[13] + 1));
        // A request presented together with flush is refused even by an idle engine
        req.op    = op_mul;
        req.tag   = 5'd28;
        req.src_a = 64'd3;
        req.src_b = 64'd3;
        req_valid = 1'b1;
        flush     = 1'b1;
        @(negedge clk);
        check("req_ready", XLEN'(req_ready), '0);
        @(posedge clk);
        #DRIVE;
        flush     = 1'b0;
        req_valid = 1'b0;
        // Both engines busy when the flush arrives
        issue(op_mulhu, M1, M1, 5'd30, M1 - 1);
        issue(op_divu, 64'd100, 64'd7, 5'd31, 64'd14);
        repeat (20) begin
            @(posedge clk);
            #DRIVE;
        end
        flush = 1'b1;
        @(posedge clk);
        #DRIVE;
        flush    = 1'b0;
        pend[30] = 1'b0;
        pend[31] = 1'b0;
        busy_mul <= 1'b0;
        busy_div <= 1'b0;
        issue(op_div, 64'hffff_ffff_ffff_ff9c, 64'd7, 5'd29, 64'hffff_ffff_ffff_fff2);
        wait_drain();
        $display("No errors");
        $finish;
    end

endmodule

// File: mdu.f
+incdir+hdl
hdl/mdu_pkg.sv
hdl/mdu_dispatch.sv
hdl/mdu_mul.sv
hdl/mdu_div.sv
hdl/mdu_wb_arbiter.sv
hdl/mdu_top.sv
verification/mdu_assertions.sv
verification/mdu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the result.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module mdu_tb -f mdu.f -o mdu_sim; then
    echo "Build failed"
    exit 1
fi

if ! ./obj_dir/mdu_sim; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0
